// File: design/alu_cmd_pkg.sv
//////////////////////////////
// Unit selector and command encodings
// Flag bit positions in the flag vector
// Shift amount width
//////////////////////////////
`default_nettype none

package alu_cmd_pkg;

	// Unit whose result goes to writeback, code 2'd3 is illegal
	typedef enum logic [1:0] {
		UNIT_ADDER = 2'd0,
		UNIT_LOGIC = 2'd1,
		UNIT_SHIFT = 2'd2
	} alu_unit_e;

	// Commands grouped by unit
	typedef enum logic [4:0] {
		CMD_ADD  = 5'h00,
		CMD_SUB  = 5'h01,
		CMD_BUF0 = 5'h08,
		CMD_BUF1 = 5'h09,
		CMD_AND  = 5'h0a,
		CMD_OR   = 5'h0b,
		CMD_XOR  = 5'h0c,
		CMD_NOT  = 5'h0d,
		CMD_NAND = 5'h0e,
		CMD_NOR  = 5'h0f,
		CMD_XNOR = 5'h10,
		CMD_SBUF = 5'h18,
		CMD_LSL  = 5'h19,
		CMD_LSR  = 5'h1a,
		CMD_ASR  = 5'h1b,
		CMD_ROL  = 5'h1c,
		CMD_ROR  = 5'h1d
	} alu_cmd_e;

	// Flag vector layout is {sf, of, cf, pf, zf}
	localparam int FLAG_SF = 4;
	localparam int FLAG_OF = 3;
	localparam int FLAG_CF = 2;
	localparam int FLAG_PF = 1;
	localparam int FLAG_ZF = 0;

	// Taken from the low bits of source1
	localparam int SHIFT_AMT_W = 5;

endpackage

`default_nettype wire

// File: design/alu_sched_pkg.sv
//////////////////////////////
// Data, tag and register typedefs
// Issue, unit output and result structs
//////////////////////////////
`default_nettype none

package alu_sched_pkg;

	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [4:0]        flags_t;
	typedef logic [5:0]        commit_tag_t;
	typedef logic [5:0]        regname_t;
	typedef logic [3:0]        flags_regname_t;

	// One operation from the scheduler
	typedef struct packed {
		logic                    valid;
		logic                    writeback;
		commit_tag_t             commit_tag;
		alu_cmd_pkg::alu_cmd_e   cmd;
		alu_cmd_pkg::alu_unit_e  unit;
		data_t                   source0;
		data_t                   source1;
		logic                    dest_sysreg;
		regname_t                dest_regname;
		logic                    flags_writeback;
		flags_regname_t          flags_regname;
	} alu_issue_t;

	// Produced by each compute unit
	typedef struct packed {
		data_t  data;
		flags_t flags;
	} alu_unit_out_t;

	// Back to the scheduler, one cycle after issue
	typedef struct packed {
		logic           valid;
		commit_tag_t    commit_tag;
		logic           sysreg;
		regname_t       dest_regname;
		logic           writeback;
		data_t          data;
		flags_t         flags;
		logic           flags_writeback;
		flags_regname_t flags_regname;
	} alu_result_t;

endpackage

`default_nettype wire

// File: design/alu_adder_unit.sv
//////////////////////////////
// Adder unit, add and subtract
// Produces sf, of, cf, pf and zf
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_adder_unit (
	input  alu_cmd_pkg::alu_cmd_e        cmd,
	input  alu_sched_pkg::data_t         source0,
	input  alu_sched_pkg::data_t         source1,
	output alu_sched_pkg::alu_unit_out_t out
);
	import alu_cmd_pkg::*;
	import alu_sched_pkg::*;

	logic            is_sub;
	data_t           operand1;
	logic [DATA_W:0] sum_ext;
	data_t           sum;
	logic            carry;

	always_comb begin
		// Subtract as source0 + ~source1 + 1
		is_sub   = (cmd == CMD_SUB);
		operand1 = is_sub ? ~source1 : source1;
		sum_ext  = {1'b0, source0} + {1'b0, operand1} + {{DATA_W{1'b0}}, is_sub};
		sum      = sum_ext[DATA_W-1:0];
		carry    = sum_ext[DATA_W];
	end

	always_comb begin
		out.data = sum;
		out.flags[FLAG_SF] = sum[DATA_W-1];
		// Same operand signs but result sign differs
		out.flags[FLAG_OF] = (source0[DATA_W-1] == operand1[DATA_W-1]) &&
			(sum[DATA_W-1] != source0[DATA_W-1]);
		// Borrow is the inverted carry on subtract
		out.flags[FLAG_CF] = is_sub ? ~carry : carry;
		// Even parity of the low byte
		out.flags[FLAG_PF] = ~^sum[7:0];
		out.flags[FLAG_ZF] = (sum == '0);
	end

endmodule

`default_nettype wire

// File: design/alu_logic_shift_unit.sv
//////////////////////////////
// Logic and shift unit
// Bitwise ops, shifts, rotates
// Flags with of held low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_logic_shift_unit (
	input  alu_cmd_pkg::alu_cmd_e        cmd,
	input  alu_sched_pkg::data_t         source0,
	input  alu_sched_pkg::data_t         source1,
	output alu_sched_pkg::alu_unit_out_t out
);
	import alu_cmd_pkg::*;
	import alu_sched_pkg::*;

	logic [SHIFT_AMT_W-1:0] amt;
	logic                   is_shift;
	data_t                  logic_data;
	data_t                  shift_data;
	logic                   shift_cf;
	logic [DATA_W:0]        ext_left;
	logic [DATA_W:0]        ext_right;
	logic [DATA_W:0]        ext_arith;
	logic [2*DATA_W-1:0]    rot_left;
	logic [2*DATA_W-1:0]    rot_right;
	data_t                  result;

	// Logic operations, unknown commands pass source0
	always_comb begin
		case (cmd)
			CMD_BUF1: logic_data = source1;
			CMD_AND:  logic_data = source0 & source1;
			CMD_OR:   logic_data = source0 | source1;
			CMD_XOR:  logic_data = source0 ^ source1;
			CMD_NOT:  logic_data = ~source0;
			CMD_NAND: logic_data = ~(source0 & source1);
			CMD_NOR:  logic_data = ~(source0 | source1);
			CMD_XNOR: logic_data = ~(source0 ^ source1);
			default:  logic_data = source0;
		endcase
	end

	// Extra bit beside the word catches the last bit shifted out
	always_comb begin
		amt       = source1[SHIFT_AMT_W-1:0];
		ext_left  = {1'b0, source0} << amt;
		ext_right = {source0, 1'b0} >> amt;
		ext_arith = $signed({source0, 1'b0}) >>> amt;
		rot_left  = {source0, source0} << amt;
		rot_right = {source0, source0} >> amt;
	end

	always_comb begin
		case (cmd)
			CMD_LSL: begin
				shift_data = ext_left[DATA_W-1:0];
				shift_cf   = ext_left[DATA_W];
			end
			CMD_LSR: begin
				shift_data = ext_right[DATA_W:1];
				shift_cf   = ext_right[0];
			end
			CMD_ASR: begin
				shift_data = ext_arith[DATA_W:1];
				shift_cf   = ext_arith[0];
			end
			CMD_ROL: begin
				shift_data = rot_left[2*DATA_W-1:DATA_W];
				// Last wrapped bit lands in bit 0
				shift_cf   = (amt != '0) && shift_data[0];
			end
			CMD_ROR: begin
				shift_data = rot_right[DATA_W-1:0];
				// Last wrapped bit lands in the MSB
				shift_cf   = (amt != '0) && shift_data[DATA_W-1];
			end
			default: begin
				shift_data = source0;
				shift_cf   = 1'b0;
			end
		endcase
	end

	always_comb begin
		is_shift = cmd inside {CMD_SBUF, CMD_LSL, CMD_LSR, CMD_ASR, CMD_ROL, CMD_ROR};
		result   = is_shift ? shift_data : logic_data;
		out.data = result;
		out.flags[FLAG_SF] = result[DATA_W-1];
		out.flags[FLAG_OF] = 1'b0;
		out.flags[FLAG_CF] = is_shift && shift_cf;
		out.flags[FLAG_PF] = ~^result[7:0];
		out.flags[FLAG_ZF] = (result == '0);
	end

	// ASR keeps the sign, a rotate keeps the number of ones
	always_comb begin
		assert final ((cmd != CMD_ASR || shift_data[DATA_W-1] == source0[DATA_W-1]) &&
			(!(cmd inside {CMD_ROL, CMD_ROR}) ||
			$countones(shift_data) == $countones(source0)))
			else $error("ASR lost the sign bit or a rotate dropped bits");
	end

endmodule

`default_nettype wire

// File: design/alu_writeback_buffer.sv
//////////////////////////////
// Writeback buffer
// Unit select, metadata and flush
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_writeback_buffer (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic                         flush,
	input  alu_sched_pkg::alu_issue_t    issue,
	input  alu_sched_pkg::alu_unit_out_t adder_out,
	input  alu_sched_pkg::alu_unit_out_t logic_shift_out,
	output alu_sched_pkg::alu_result_t   result
);
	import alu_cmd_pkg::*;
	import alu_sched_pkg::*;

	alu_unit_out_t selected;

	// Logic and shift share one unit output
	always_comb begin
		case (issue.unit)
			UNIT_LOGIC, UNIT_SHIFT: selected = logic_shift_out;
			default:                selected = adder_out;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			result <= '0;
		end else if (flush) begin
			// Cancel whatever was about to appear
			result <= '0;
		end else begin
			result.valid           <= issue.valid;
			result.commit_tag      <= issue.commit_tag;
			result.sysreg          <= issue.dest_sysreg;
			result.dest_regname    <= issue.dest_regname;
			result.writeback       <= issue.writeback;
			result.data            <= selected.data;
			result.flags           <= selected.flags;
			result.flags_writeback <= issue.flags_writeback;
			result.flags_regname   <= issue.flags_regname;
		end
	end

	// Scheduler never issues the spare unit code
	a_legal_unit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		issue.valid |-> (issue.unit inside {UNIT_ADDER, UNIT_LOGIC, UNIT_SHIFT}))
		else $error("valid issue with illegal unit code %0d", issue.unit);

	// Flushed edge leaves an empty result behind
	a_flush_clears: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		flush |=> (!result.valid && (result == '0)))
		else $error("result not cleared after flush");

endmodule

`default_nettype wire

// File: design/alu2_exec.sv
//////////////////////////////
// Integer execution lane top
// Adder, logic/shift, writeback
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu2_exec (
	input  logic                       iCLOCK,
	input  logic                       inRESET,
	input  logic                       flush,
	input  alu_sched_pkg::alu_issue_t  issue,
	output alu_sched_pkg::alu_result_t result
);
	import alu_sched_pkg::*;

	alu_unit_out_t adder_out;
	alu_unit_out_t logic_shift_out;

	// Both units compute every cycle
	alu_adder_unit u_adder (
		.cmd     (issue.cmd),
		.source0 (issue.source0),
		.source1 (issue.source1),
		.out     (adder_out)
	);

	alu_logic_shift_unit u_logic_shift (
		.cmd     (issue.cmd),
		.source0 (issue.source0),
		.source1 (issue.source1),
		.out     (logic_shift_out)
	);

	alu_writeback_buffer u_writeback (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.flush           (flush),
		.issue           (issue),
		.adder_out       (adder_out),
		.logic_shift_out (logic_shift_out),
		.result          (result)
	);

endmodule

`default_nettype wire

// File: verif/alu2_exec_tb.sv
//////////////////////////////
// Testbench for the execution lane
// Clock, reset, directed and random issues
// Reference model and checking assertions
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu2_exec_tb;
	import alu_cmd_pkg::*;
	import alu_sched_pkg::*;

	logic        iCLOCK;
	logic        inRESET;
	logic        flush;
	alu_issue_t  issue;
	alu_result_t result;
	alu_result_t exp_q;
	int          errors;
	int          timeouts;

	alu_cmd_e logic_cmds[9] = '{CMD_BUF0, CMD_BUF1, CMD_AND, CMD_OR, CMD_XOR,
		CMD_NOT, CMD_NAND, CMD_NOR, CMD_XNOR};
	alu_cmd_e shift_cmds[6] = '{CMD_SBUF, CMD_LSL, CMD_LSR, CMD_ASR, CMD_ROL, CMD_ROR};

	alu2_exec dut (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.flush   (flush),
		.issue   (issue),
		.result  (result)
	);

	always #20 iCLOCK = ~iCLOCK;

	// Flags from a result word plus of and cf
	function automatic flags_t make_flags(data_t d, logic of, logic cf);
		flags_t f;
		f[FLAG_SF] = d[31];
		f[FLAG_OF] = of;
		f[FLAG_CF] = cf;
		f[FLAG_PF] = ~^d[7:0];
		f[FLAG_ZF] = (d == 32'h0);
		return f;
	endfunction

	function automatic alu_unit_out_t adder_model(alu_cmd_e cmd, data_t a, data_t b);
		alu_unit_out_t o;
		logic [32:0]   s;
		logic          of;
		if (cmd == CMD_SUB) begin
			o.data = a - b;
			of = (a[31] != b[31]) && (o.data[31] != a[31]);
			o.flags = make_flags(o.data, of, a < b);
		end else begin
			s = {1'b0, a} + {1'b0, b};
			o.data = s[31:0];
			of = (a[31] == b[31]) && (o.data[31] != a[31]);
			o.flags = make_flags(o.data, of, s[32]);
		end
		return o;
	endfunction

	// Shifts done one bit at a time
	function automatic alu_unit_out_t logic_shift_model(alu_cmd_e cmd, data_t a, data_t b);
		alu_unit_out_t o;
		data_t         r;
		logic          cf;
		int            n;
		r = a;
		cf = 1'b0;
		n = b[4:0];
		case (cmd)
			CMD_BUF1: r = b;
			CMD_AND:  r = a & b;
			CMD_OR:   r = a | b;
			CMD_XOR:  r = a ^ b;
			CMD_NOT:  r = ~a;
			CMD_NAND: r = ~(a & b);
			CMD_NOR:  r = ~(a | b);
			CMD_XNOR: r = ~(a ^ b);
			CMD_LSL: for (int i = 0; i < n; i++) begin
				cf = r[31];
				r = r << 1;
			end
			CMD_LSR: for (int i = 0; i < n; i++) begin
				cf = r[0];
				r = r >> 1;
			end
			CMD_ASR: for (int i = 0; i < n; i++) begin
				cf = r[0];
				r = {r[31], r[31:1]};
			end
			CMD_ROL: for (int i = 0; i < n; i++) begin
				r = {r[30:0], r[31]};
				cf = r[0];
			end
			CMD_ROR: for (int i = 0; i < n; i++) begin
				r = {r[0], r[31:1]};
				cf = r[31];
			end
			default: r = a;
		endcase
		o.data = r;
		o.flags = make_flags(r, 1'b0, cf);
		return o;
	endfunction

	function automatic alu_result_t expected_result(alu_issue_t is, logic fl);
		alu_result_t   e;
		alu_unit_out_t u;
		e = '0;
		if (!fl) begin
			if (is.unit == UNIT_ADDER)
				u = adder_model(is.cmd, is.source0, is.source1);
			else
				u = logic_shift_model(is.cmd, is.source0, is.source1);
			e.valid           = is.valid;
			e.commit_tag      = is.commit_tag;
			e.sysreg          = is.dest_sysreg;
			e.dest_regname    = is.dest_regname;
			e.writeback       = is.writeback;
			e.data            = u.data;
			e.flags           = u.flags;
			e.flags_writeback = is.flags_writeback;
			e.flags_regname   = is.flags_regname;
		end
		return e;
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			exp_q <= '0;
		else
			exp_q <= expected_result(issue, flush);
	end

	task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		errors++;
	endtask

	// Result must match what the model stored at the previous edge
	a_valid: assert property (@(posedge iCLOCK) result.valid == exp_q.valid)
		else report_value("result.valid", $sampled(result.valid), $sampled(exp_q.valid));
	a_tag: assert property (@(posedge iCLOCK) result.commit_tag == exp_q.commit_tag)
		else report_value("result.commit_tag", $sampled(result.commit_tag),
			$sampled(exp_q.commit_tag));
	a_sysreg: assert property (@(posedge iCLOCK) result.sysreg == exp_q.sysreg)
		else report_value("result.sysreg", $sampled(result.sysreg), $sampled(exp_q.sysreg));
	a_dest: assert property (@(posedge iCLOCK) result.dest_regname == exp_q.dest_regname)
		else report_value("result.dest_regname", $sampled(result.dest_regname),
			$sampled(exp_q.dest_regname));
	a_wb: assert property (@(posedge iCLOCK) result.writeback == exp_q.writeback)
		else report_value("result.writeback", $sampled(result.writeback),
			$sampled(exp_q.writeback));
	a_data: assert property (@(posedge iCLOCK) result.data == exp_q.data)
		else report_value("result.data", $sampled(result.data), $sampled(exp_q.data));
	a_flags: assert property (@(posedge iCLOCK) result.flags == exp_q.flags)
		else report_value("result.flags", $sampled(result.flags), $sampled(exp_q.flags));
	a_fwb: assert property (@(posedge iCLOCK) result.flags_writeback == exp_q.flags_writeback)
		else report_value("result.flags_writeback", $sampled(result.flags_writeback),
			$sampled(exp_q.flags_writeback));
	a_freg: assert property (@(posedge iCLOCK) result.flags_regname == exp_q.flags_regname)
		else report_value("result.flags_regname", $sampled(result.flags_regname),
			$sampled(exp_q.flags_regname));

	// One operation on the falling edge, metadata random
	task automatic drive_op(alu_unit_e unit, alu_cmd_e cmd, data_t a, data_t b, logic fl);
		@(negedge iCLOCK);
		issue.valid           = 1'b1;
		issue.writeback       = $urandom_range(0, 1);
		issue.commit_tag      = $urandom_range(0, 63);
		issue.cmd             = cmd;
		issue.unit            = unit;
		issue.source0         = a;
		issue.source1         = b;
		issue.dest_sysreg     = $urandom_range(0, 1);
		issue.dest_regname    = $urandom_range(0, 63);
		issue.flags_writeback = $urandom_range(0, 1);
		issue.flags_regname   = $urandom_range(0, 15);
		flush                 = fl;
	endtask

	task automatic drive_idle(logic fl);
		@(negedge iCLOCK);
		issue = '0;
		flush = fl;
	endtask

	task automatic random_op();
		int u;
		u = $urandom_range(0, 2);
		if (u == 0)
			drive_op(UNIT_ADDER, $urandom_range(0, 1) ? CMD_SUB : CMD_ADD,
				$urandom, $urandom, 1'b0);
		else if (u == 1)
			drive_op(UNIT_LOGIC, logic_cmds[$urandom_range(0, 8)], $urandom, $urandom, 1'b0);
		else
			drive_op(UNIT_SHIFT, shift_cmds[$urandom_range(0, 5)], $urandom, $urandom, 1'b0);
	endtask

	// Stops a hung run
	initial begin
		#2000000;
		$display("Watchdog expired before the run finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int cnt;
		void'($urandom(32'h43ab));
		errors = 0;
		timeouts = 0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		flush = 1'b0;
		issue = '0;
		repeat (5) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		drive_idle(1'b0);

		// Adder corner cases, then random
		drive_op(UNIT_ADDER, CMD_ADD, 32'h7fffffff, 32'h1, 1'b0);
		drive_op(UNIT_ADDER, CMD_ADD, 32'hffffffff, 32'h1, 1'b0);
		drive_op(UNIT_ADDER, CMD_SUB, 32'h1, 32'h2, 1'b0);
		drive_op(UNIT_ADDER, CMD_SUB, 32'h5, 32'h5, 1'b0);
		drive_op(UNIT_ADDER, CMD_SUB, 32'h80000000, 32'h1, 1'b0);
		repeat (20)
			drive_op(UNIT_ADDER, $urandom_range(0, 1) ? CMD_SUB : CMD_ADD,
				$urandom, $urandom, 1'b0);

		foreach (logic_cmds[i])
			repeat (4) drive_op(UNIT_LOGIC, logic_cmds[i], $urandom, $urandom, 1'b0);

		// Amount zero, amount 31 and random amounts
		foreach (shift_cmds[i]) begin
			drive_op(UNIT_SHIFT, shift_cmds[i], $urandom, 32'h0, 1'b0);
			drive_op(UNIT_SHIFT, shift_cmds[i], $urandom, 32'h1f, 1'b0);
			repeat (4) drive_op(UNIT_SHIFT, shift_cmds[i], $urandom, $urandom, 1'b0);
		end

		// Back-to-back mixed units, then an idle cycle
		repeat (30) random_op();
		drive_idle(1'b0);
		random_op();

		// Flush with an issue, resume, flush while idle
		drive_op(UNIT_ADDER, CMD_ADD, $urandom, $urandom, 1'b1);
		random_op();
		drive_idle(1'b1);
		random_op();
		drive_idle(1'b0);

		cnt = 0;
		while (result.valid && cnt < 10) begin
			@(negedge iCLOCK);
			cnt++;
		end
		if (result.valid) begin
			$display("Result valid did not drop after the last issue");
			timeouts++;
		end
		repeat (2) @(negedge iCLOCK);

		$display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: alu2_exec.f
design/alu_cmd_pkg.sv
design/alu_sched_pkg.sv
design/alu_adder_unit.sv
design/alu_logic_shift_unit.sv
design/alu_writeback_buffer.sv
design/alu2_exec.sv
verif/alu2_exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execution lane testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -sv \
	--top-module alu2_exec_tb \
	-f alu2_exec.f \
	-o alu2_exec_sim

set -o pipefail
./obj_dir/alu2_exec_sim | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation finished without failures"
